// File: files.f
hw/fetch_pkg.sv
hw/machine_csr.sv
hw/btac.sv
hw/fetch_stage.sv
hw/wb_fetch_master.sv
hw/fetch_top.sv
bench/tb_clock.sv
bench/wb_rom_model.sv
bench/fetch_tb.sv

// File: bench/fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_tb
  import fetch_pkg::*;
();

  // About 300 fetches at up to 9 cycles each, plus idle stretches
  localparam int cycle_limit = 4000;

  logic clock;
  logic reset;
  csr_write_t csr_write;
  logic trap;
  logic mret;
  logic fence;
  logic [xlen-1:0] fence_npc;
  logic halt;
  logic clear;
  resolve_t resolve0;
  resolve_t resolve1;
  fetch_bundle_t bundle;
  wb_m2s_t wb_out;
  wb_s2m_t wb_in;

  int cycle_count;
  int bundle_count;
  logic armed;                           // Redirect awaiting its first bundle
  logic [1:0] skip;
  logic [xlen-1:0] redirect_target;
  logic [xlen-1:0] expected_pc;
  logic [xlen-1:0] expected_next;        // Sequential, or the trained jump target
  logic expect_taken;
  logic watch_on [2];
  logic [xlen-1:0] watch_pc [2];
  logic [xlen-1:0] watch_tgt [2];
  logic prev_stb;
  logic prev_cyc;
  logic prev_halt;
  logic [xlen-1:0] prev_adr;

  tb_clock u_clock (.clock(clock), .reset(reset));

  wb_rom_model u_rom (.clock(clock), .reset(reset), .wb_out(wb_out), .wb_in(wb_in));

  fetch_top u_dut (
    .clock     (clock),
    .reset     (reset),
    .csr_write (csr_write),
    .trap      (trap),
    .mret      (mret),
    .fence     (fence),
    .fence_npc (fence_npc),
    .halt      (halt),
    .clear     (clear),
    .resolve0  (resolve0),
    .resolve1  (resolve1),
    .bundle    (bundle),
    .wb_out    (wb_out),
    .wb_in     (wb_in)
  );

  function automatic logic [fetch_width-1:0] rom_word(input logic [xlen-1:0] addr);
    return {~addr, addr};
  endfunction

  function automatic resolve_t build_resolve(input logic [xlen-1:0] pc,
                                             input logic [xlen-1:0] addr,
                                             input logic taken,
                                             input resolve_kind_t kind);
    resolve_t r;
    r.valid = 1'b1;
    r.pc = pc;
    r.npc = pc + 32'd4;
    r.addr = addr;
    r.taken = taken;
    r.kind = kind;
    return r;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    $display("FAILED %s got %h expected %h", name, got, exp);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      report_failure("Timeout, the run did not finish within the cycle limit");
    end
  end

  always @(negedge clock) begin
    if (reset) begin
      assert (!wb_out.stb || wb_out.cyc) else report_failure("stb high without cyc");
      assert (wb_out.we == 1'b0) else report_value("wb_out.we", wb_out.we, 0);
      assert (wb_out.sel == {wb_sel_bits{1'b1}})
        else report_value("wb_out.sel", wb_out.sel, {wb_sel_bits{1'b1}});
      if (prev_stb && wb_out.stb) begin
        assert (wb_out.adr == prev_adr) else report_value("wb_out.adr", wb_out.adr, prev_adr);
      end
      if (clear) begin
        assert (!wb_out.cyc) else report_failure("Wishbone cycle opened before clear dropped");
      end
      if (halt && prev_halt) begin
        assert (!(wb_out.cyc && !prev_cyc)) else report_failure("Wishbone cycle opened in halt");
      end
      if (bundle.valid) begin
        if (armed && skip == 2'd0) begin
          expected_pc = redirect_target;
          armed <= 1'b0;
        end else begin
          expected_pc = expected_next;
        end
        assert (bundle.pc == expected_pc) else report_value("bundle.pc", bundle.pc, expected_pc);
        assert (bundle.rdata == rom_word(expected_pc))
          else report_value("bundle.rdata", bundle.rdata, rom_word(expected_pc));
        expect_taken = 1'b0;
        expected_next = expected_pc + 32'd8;
        for (int i = 0; i < 2; i++) begin
          if (watch_on[i] && expected_pc == watch_pc[i]) begin
            expect_taken = 1'b1;
            expected_next = watch_tgt[i];
            assert (bundle.taddr == watch_tgt[i])
              else report_value("bundle.taddr", bundle.taddr, watch_tgt[i]);
          end
        end
        assert (bundle.taken == expect_taken)
          else report_value("bundle.taken", bundle.taken, expect_taken);
        bundle_count <= bundle_count + 1;
      end
      if (armed && skip != 2'd0) begin
        skip <= skip - 2'd1;
      end
    end
    prev_stb = wb_out.stb;
    prev_cyc = wb_out.cyc;
    prev_adr = wb_out.adr;
    prev_halt = halt;
  end

  task automatic wait_bundles(input int n);
    int goal;
    goal = bundle_count + n;
    while (bundle_count < goal) @(negedge clock);
  endtask

  task automatic wait_redirect();
    while (armed) @(negedge clock);
  endtask

  // Called on a falling edge, in the cycle the redirect input is driven
  task automatic arm_target(input logic [xlen-1:0] tgt);
    armed <= 1'b1;
    skip <= 2'd1;                        // A registered trap may still let one old bundle out
    redirect_target <= tgt;
  endtask

  task automatic write_csr(input logic sel, input logic [xlen-1:0] data);
    @(negedge clock);
    csr_write.enable = 1'b1;
    csr_write.sel = sel;
    csr_write.data = data;
    @(negedge clock);
    csr_write.enable = 1'b0;
  endtask

  task automatic pulse_trap_mret(input logic do_trap, input logic do_mret,
                                 input logic [xlen-1:0] tgt);
    @(negedge clock);
    arm_target(tgt);
    trap = do_trap;
    mret = do_mret;
    @(negedge clock);
    trap = 1'b0;
    mret = 1'b0;
    wait_redirect();
  endtask

  task automatic pulse_resolve(input resolve_t r, input logic [xlen-1:0] tgt);
    @(negedge clock);
    arm_target(tgt);
    resolve0 = r;
    @(negedge clock);
    resolve0 = '0;
    wait_redirect();
  endtask

  task automatic pulse_fence(input logic [xlen-1:0] tgt);
    @(negedge clock);
    arm_target(tgt);
    fence = 1'b1;
    fence_npc = tgt;
    @(negedge clock);
    fence = 1'b0;
    wait_redirect();
  endtask

  initial begin
    csr_write = '0;
    trap = 1'b0;
    mret = 1'b0;
    fence = 1'b0;
    fence_npc = '0;
    halt = 1'b0;
    clear = 1'b1;
    resolve0 = '0;
    resolve1 = '0;
    cycle_count = 0;
    bundle_count = 0;
    armed = 1'b1;                        // First bundle must be the reset vector
    skip = 2'd0;
    redirect_target = reset_vector;
    expected_next = reset_vector;
    expect_taken = 1'b0;
    watch_on[0] = 1'b0;
    watch_on[1] = 1'b0;
    watch_pc[0] = 32'h0000_3000;
    watch_tgt[0] = 32'h0000_3400;
    watch_pc[1] = 32'h0000_5000;
    watch_tgt[1] = 32'h0000_5800;
    wait (reset === 1'b1);
    repeat (4) @(negedge clock);
    clear = 1'b0;
    wait_bundles(60);

    write_csr(csr_sel_mtvec, 32'h0000_1000);
    write_csr(csr_sel_mepc, 32'h0000_2040);
    pulse_trap_mret(1'b1, 1'b0, 32'h0000_1000);
    wait_bundles(5);
    pulse_trap_mret(1'b0, 1'b1, 32'h0000_2040);
    wait_bundles(5);
    pulse_trap_mret(1'b1, 1'b1, 32'h0000_1000);
    wait_bundles(5);

    // Training a cold entry mispredicts, so it redirects too
    pulse_resolve(build_resolve(32'h0000_3000, 32'h0000_3400, 1'b1, kind_jal), 32'h0000_3400);
    watch_on[0] = 1'b1;
    pulse_fence(32'h0000_3000);
    wait_bundles(4);
    pulse_resolve(build_resolve(32'h0000_5004, 32'h0000_5800, 1'b1, kind_jal), 32'h0000_5800);
    watch_on[1] = 1'b1;
    pulse_fence(32'h0000_5000);
    wait_bundles(4);

    watch_on[0] = 1'b0;
    pulse_resolve(build_resolve(32'h0000_3000, 32'h0000_3400, 1'b0, kind_branch), 32'h0000_3004);
    wait_bundles(5);
    pulse_resolve(build_resolve(32'h0000_6000, 32'h0000_6800, 1'b1, kind_jalr), 32'h0000_6800);
    wait_bundles(5);
    pulse_fence(32'h0000_7000);
    wait_bundles(5);

    @(negedge clock);
    halt = 1'b1;
    repeat (20) @(negedge clock);
    halt = 1'b0;
    wait_bundles(20);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/wb_rom_model.sv
`timescale 1ns/1ns
`default_nettype none

module wb_rom_model
  import fetch_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  wb_m2s_t wb_out,
  output wb_s2m_t wb_in
);

  logic [31:0] rng_q;
  logic active_q;
  logic [1:0] wait_left_q;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  always @(posedge clock) begin
    if (reset == 1'b0) begin
      wb_in.ack <= 1'b0;
      wb_in.dat <= '0;
      active_q <= 1'b0;
      wait_left_q <= '0;
      rng_q <= 32'hd22c;
    end else if (wb_in.ack) begin
      wb_in.ack <= 1'b0;                 // Single-cycle ack
    end else if (wb_out.cyc && wb_out.stb) begin
      if (!active_q) begin
        active_q <= 1'b1;
        rng_q <= xorshift32(rng_q);
        wait_left_q <= rng_q[1:0];       // 0 to 3 wait states
      end else if (wait_left_q == 2'd0) begin
        wb_in.ack <= 1'b1;
        wb_in.dat <= {~wb_out.adr, wb_out.adr};
        active_q <= 1'b0;
      end else begin
        wait_left_q <= wait_left_q - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;          // 40 ns period
  end

  initial begin
    reset = 1'b0;
    repeat (3) @(posedge clock);
    reset <= 1'b1;
  end

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top
  import fetch_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  csr_write_t      csr_write,
  input  logic            trap,
  input  logic            mret,
  input  logic            fence,
  input  logic [xlen-1:0] fence_npc,
  input  logic            halt,
  input  logic            clear,
  input  resolve_t        resolve0,
  input  resolve_t        resolve1,
  output fetch_bundle_t   bundle,
  output wb_m2s_t         wb_out,
  input  wb_s2m_t         wb_in
);

  csr_out_t csr_out;
  btac_in_t btac_in;
  btac_out_t btac_out;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  machine_csr u_csr (
    .clock     (clock),
    .reset     (reset),
    .csr_write (csr_write),
    .trap      (trap),
    .mret      (mret),
    .csr_out   (csr_out)
  );

  btac u_btac (
    .clock    (clock),
    .reset    (reset),
    .btac_in  (btac_in),
    .resolve0 (resolve0),
    .resolve1 (resolve1),
    .btac_out (btac_out)
  );

  fetch_stage u_fetch (
    .clock     (clock),
    .reset     (reset),
    .csr_out   (csr_out),
    .btac_out  (btac_out),
    .btac_in   (btac_in),
    .fence     (fence),
    .fence_npc (fence_npc),
    .halt      (halt),
    .clear     (clear),
    .mem_rsp   (mem_rsp),
    .mem_req   (mem_req),
    .bundle    (bundle)
  );

  wb_fetch_master u_wb (
    .clock   (clock),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .wb_out  (wb_out),
    .wb_in   (wb_in)
  );

endmodule

`default_nettype wire

// File: hw/wb_fetch_master.sv
`timescale 1ns/1ns
`default_nettype none

module wb_fetch_master
  import fetch_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp,
  output wb_m2s_t  wb_out,
  input  wb_s2m_t  wb_in
);

  typedef enum logic {bus_idle, bus_active} bus_state_t;

  bus_state_t state_q;
  logic [xlen-1:0] adr_q;
  logic ready_q;
  logic [fetch_width-1:0] rdata_q;
  logic accept;
  logic done;

  assign accept = state_q == bus_idle && mem_req.valid;
  assign done = state_q == bus_active && wb_in.ack;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state_q <= bus_idle;
      ready_q <= 1'b0;
    end else begin
      ready_q <= done;                   // One-cycle pulse after ack
      if (accept) begin
        state_q <= bus_active;
      end else if (done) begin
        state_q <= bus_idle;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      adr_q <= mem_req.addr;             // Held until ack
    end
    if (done) begin
      rdata_q <= wb_in.dat;
    end
  end

  always_comb begin
    wb_out.cyc = state_q == bus_active;
    wb_out.stb = state_q == bus_active;
    wb_out.we = 1'b0;
    wb_out.adr = adr_q;
    wb_out.sel = '1;
  end

  always_comb begin
    mem_rsp.ready = ready_q;
    mem_rsp.rdata = rdata_q;
  end

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
  import fetch_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  csr_out_t        csr_out,
  input  btac_out_t       btac_out,
  output btac_in_t        btac_in,
  input  logic            fence,
  input  logic [xlen-1:0] fence_npc,
  input  logic            halt,
  input  logic            clear,
  input  mem_rsp_t        mem_rsp,
  output mem_req_t        mem_req,
  output fetch_bundle_t   bundle
);

  fetch_state_t state_q;
  fetch_state_t state_d;
  logic [xlen-1:0] pc_q;                 // In-flight address, or next one when none pending
  logic [xlen-1:0] pc_d;
  logic pending_q;
  logic pending_d;
  fetch_bundle_t bundle_q;

  logic redirect;
  logic [xlen-1:0] target;
  logic advance;
  logic [xlen-1:0] next_pc;
  logic issue;
  logic spec;

  always_comb begin
    redirect = 1'b1;
    if (csr_out.trap) begin
      target = csr_out.mtvec;
    end else if (csr_out.mret) begin
      target = csr_out.mepc;
    end else if (btac_out.pred_miss) begin
      target = btac_out.pred_maddr;
    end else if (fence) begin
      target = fence_npc;
    end else begin
      redirect = 1'b0;
      target = pc_q;
    end
  end

  // Data arrives for a fetch that is still on the right path
  assign advance = state_q == busy && pending_q && mem_rsp.ready && !redirect;
  assign next_pc = btac_out.pred_branch ? btac_out.pred_baddr : pc_q + 32'd8;

  always_comb begin
    state_d = state_q;
    pc_d = pc_q;
    issue = 1'b0;
    spec = 1'b0;
    case (state_q)
      idle: begin
        if (!clear) begin
          state_d = busy;
          pc_d = reset_vector;
          issue = !halt;
        end
      end
      busy: begin
        if (pending_q && mem_rsp.ready) begin
          pc_d = redirect ? target : next_pc;
          issue = !halt;
          spec = redirect || btac_out.pred_branch;
        end else if (pending_q) begin
          if (redirect) begin
            pc_d = target;
            state_d = ctrl;                // Old fetch must be drained
          end
        end else begin
          pc_d = target;                   // Nothing in flight, redirect is free
          issue = !halt;
          spec = redirect;
        end
      end
      ctrl: begin
        pc_d = target;
        if (mem_rsp.ready) begin
          state_d = busy;                  // Stale data is dropped here
          issue = !halt;
          spec = 1'b1;
        end
      end
      default: begin
        state_d = idle;
      end
    endcase
    pending_d = issue || (pending_q && !mem_rsp.ready);
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state_q <= idle;
      pc_q <= reset_vector;
      pending_q <= 1'b0;
    end else begin
      state_q <= state_d;
      pc_q <= pc_d;
      pending_q <= pending_d;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      bundle_q.valid <= 1'b0;
    end else begin
      bundle_q.valid <= advance;
      if (advance) begin
        bundle_q.pc <= pc_q;
        bundle_q.rdata <= mem_rsp.rdata;
        bundle_q.taken <= btac_out.pred_branch;
        bundle_q.taddr <= btac_out.pred_branch ? btac_out.pred_baddr : '0;
      end
    end
  end

  always_comb begin
    mem_req.valid = issue;
    mem_req.spec = spec;
    mem_req.addr = pc_d;
  end

  always_comb begin
    btac_in.pc = pc_q;
    btac_in.taken = btac_out.pred_branch;  // Already masked by stall
    btac_in.taddr = btac_out.pred_baddr;
    btac_in.tpc = btac_out.pred_pc;
    btac_in.stall = !advance;
    btac_in.clear = clear;
  end

  assign bundle = bundle_q;

endmodule

`default_nettype wire

// File: hw/btac.sv
`timescale 1ns/1ns
`default_nettype none

module btac
  import fetch_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  btac_in_t  btac_in,
  input  resolve_t  resolve0,
  input  resolve_t  resolve1,
  output btac_out_t btac_out
);

  logic [btac_entries-1:0] valid_q;
  logic [btac_tag_bits-1:0] tag_q [btac_entries];
  logic [xlen-1:0] target_q [btac_entries];

  logic last_taken_q;                    // Last prediction fetch acted on
  logic [xlen-1:0] last_taddr_q;
  logic [xlen-1:0] last_tpc_q;

  logic [xlen-1:0] look_pc1;
  logic [btac_index_bits-1:0] look_idx0;
  logic [btac_index_bits-1:0] look_idx1;
  logic hit0;
  logic hit1;

  resolve_t slot [2];
  logic [btac_index_bits-1:0] ridx [2];
  logic [1:0] rhit;
  logic [1:0] jump;
  logic [1:0] miss;
  logic [1:0] upd_en;
  logic [xlen-1:0] actual [2];
  logic [xlen-1:0] predicted [2];

  function automatic logic [btac_index_bits-1:0] index_of(input logic [xlen-1:0] addr);
    return addr[btac_index_bits+1:2];
  endfunction

  function automatic logic [btac_tag_bits-1:0] tag_of(input logic [xlen-1:0] addr);
    return addr[xlen-1:btac_index_bits+2];
  endfunction

  assign look_pc1 = btac_in.pc + 32'd4;
  assign look_idx0 = index_of(btac_in.pc);
  assign look_idx1 = index_of(look_pc1);
  assign hit0 = valid_q[look_idx0] && tag_q[look_idx0] == tag_of(btac_in.pc);
  assign hit1 = valid_q[look_idx1] && tag_q[look_idx1] == tag_of(look_pc1);

  assign slot[0] = resolve0;
  assign slot[1] = resolve1;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      ridx[i] = index_of(slot[i].pc);
      rhit[i] = valid_q[ridx[i]] && tag_q[ridx[i]] == tag_of(slot[i].pc);
      jump[i] = slot[i].kind != kind_branch || slot[i].taken;
      actual[i] = jump[i] ? slot[i].addr : slot[i].npc;
      if (last_taken_q && slot[i].pc == last_tpc_q) begin
        predicted[i] = last_taddr_q;
      end else if (rhit[i]) begin
        predicted[i] = target_q[ridx[i]];
      end else begin
        predicted[i] = slot[i].npc;
      end
      miss[i] = slot[i].valid && actual[i] != predicted[i];
    end
    upd_en[0] = slot[0].valid;
    upd_en[1] = slot[1].valid && !miss[0];  // Slot 1 is wrong path after a slot 0 miss
  end

  always_comb begin
    btac_out.pred_branch = (hit0 || hit1) && !btac_in.stall;
    btac_out.pred_baddr = hit0 ? target_q[look_idx0] : target_q[look_idx1];
    btac_out.pred_pc = hit0 ? btac_in.pc : look_pc1;
    btac_out.pred_miss = miss[0] || miss[1];
    btac_out.pred_maddr = miss[0] ? actual[0] : actual[1];
  end

  // Slot 1 first so slot 0 wins on a shared index
  always_ff @(posedge clock) begin
    if (reset == 1'b0 || btac_in.clear) begin
      valid_q <= '0;
    end else begin
      for (int i = 1; i >= 0; i--) begin
        if (upd_en[i] && jump[i]) begin
          valid_q[ridx[i]] <= 1'b1;
        end else if (upd_en[i] && rhit[i]) begin
          valid_q[ridx[i]] <= 1'b0;        // Not-taken branch drops its entry
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 1; i >= 0; i--) begin
      if (upd_en[i] && jump[i]) begin
        tag_q[ridx[i]] <= tag_of(slot[i].pc);
        target_q[ridx[i]] <= slot[i].addr;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0 || btac_in.clear || btac_out.pred_miss) begin
      last_taken_q <= 1'b0;
    end else if (btac_in.taken) begin
      last_taken_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (btac_in.taken) begin
      last_taddr_q <= btac_in.taddr;
      last_tpc_q <= btac_in.tpc;
    end
  end

endmodule

`default_nettype wire

// File: hw/machine_csr.sv
`timescale 1ns/1ns
`default_nettype none

module machine_csr
  import fetch_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  csr_write_t csr_write,
  input  logic       trap,
  input  logic       mret,
  output csr_out_t   csr_out
);

  logic [xlen-1:0] mtvec_q;
  logic [xlen-1:0] mepc_q;
  logic trap_q;
  logic mret_q;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      mtvec_q <= '0;
      mepc_q <= '0;
      trap_q <= 1'b0;
      mret_q <= 1'b0;
    end else begin
      trap_q <= trap;                    // One cycle late so a same-cycle write settles
      mret_q <= mret;
      if (csr_write.enable && csr_write.sel == csr_sel_mtvec) begin
        mtvec_q <= csr_write.data;
      end
      if (csr_write.enable && csr_write.sel == csr_sel_mepc) begin
        mepc_q <= csr_write.data;
      end
    end
  end

  always_comb begin
    csr_out.trap = trap_q;
    csr_out.mret = mret_q && !trap_q;    // Trap wins
    csr_out.mtvec = mtvec_q;
    csr_out.mepc = mepc_q;
  end

endmodule

`default_nettype wire

// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam int xlen = 32;
  localparam int fetch_width = 64;
  localparam int wb_sel_bits = fetch_width / 8;

  localparam int btac_entries = 64;
  localparam int btac_index_bits = $clog2(btac_entries);
  localparam int btac_tag_bits = xlen - btac_index_bits - 2;

  localparam logic [xlen-1:0] reset_vector = 32'h0000_0000;

  localparam logic csr_sel_mtvec = 1'b0;
  localparam logic csr_sel_mepc = 1'b1;

  typedef enum logic [1:0] {idle, busy, ctrl} fetch_state_t;

  typedef enum logic [1:0] {kind_jal, kind_jalr, kind_branch} resolve_kind_t;

  typedef struct packed {
    logic enable;
    logic sel;                           // 0 mtvec, 1 mepc
    logic [xlen-1:0] data;
  } csr_write_t;

  typedef struct packed {
    logic trap;
    logic mret;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
  } csr_out_t;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] npc;
    logic [xlen-1:0] addr;               // Actual target
    logic taken;
    resolve_kind_t kind;
  } resolve_t;

  typedef struct packed {
    logic [xlen-1:0] pc;                 // Lookup pc, slot 1 is pc+4
    logic taken;
    logic [xlen-1:0] taddr;
    logic [xlen-1:0] tpc;
    logic stall;
    logic clear;
  } btac_in_t;

  typedef struct packed {
    logic pred_branch;
    logic [xlen-1:0] pred_baddr;
    logic [xlen-1:0] pred_pc;
    logic pred_miss;
    logic [xlen-1:0] pred_maddr;
  } btac_out_t;

  typedef struct packed {
    logic valid;
    logic spec;
    logic [xlen-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic ready;
    logic [fetch_width-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] pc;
    logic [fetch_width-1:0] rdata;
    logic taken;
    logic [xlen-1:0] taddr;
  } fetch_bundle_t;

  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    logic [xlen-1:0] adr;
    logic [wb_sel_bits-1:0] sel;
  } wb_m2s_t;

  typedef struct packed {
    logic ack;
    logic [fetch_width-1:0] dat;
  } wb_s2m_t;

endpackage

`default_nettype wire
